//--- rtl/dbg_pkg.sv
package dbg_pkg;

   // largest packet in flits, without the host length word
   localparam int MAX_PKT_LEN = 8;
   localparam int LEN_W       = $clog2(MAX_PKT_LEN + 1);
   localparam int IDX_W       = $clog2(MAX_PKT_LEN);

   typedef logic [15:0] dbg_word_t;

   typedef struct packed {
      dbg_word_t payload;
      logic      last;
   } dbg_flit_t;

   // carried in flit 2 of every packet
   typedef enum logic [15:0] {
      REQ_READ  = 16'h0000,
      REQ_WRITE = 16'h0001,
      RESP_DATA = 16'h0002,
      RESP_ACK  = 16'h0003,
      RESP_ERR  = 16'h0004
   } dbg_type_e;

   typedef enum logic [15:0] {
      REG_SYSTEM_ID = 16'h0000,
      REG_NUM_MOD   = 16'h0001,
      REG_RESET     = 16'h0002
   } reg_addr_e;

   // ring station ids
   localparam dbg_word_t HOST_ID = 16'd0;
   localparam dbg_word_t CTRL_ID = 16'd1;

   localparam dbg_word_t SYSTEM_ID = 16'hdead;
   localparam dbg_word_t NUM_MOD   = 16'd1;   // modules on the ring besides the host

endpackage

//--- rtl/dii_link_if.sv
interface dii_link_if
   import dbg_pkg::*;
   ();

   dbg_word_t flit;
   logic      last;
   logic      valid;
   logic      ready;

   // a flit moves in every cycle with valid and ready both high
   modport source (
      output flit, last, valid,
      input  ready
   );

   modport sink (
      input  flit, last, valid,
      output ready
   );

endinterface

//--- rtl/host_rx_packetizer.sv
module host_rx_packetizer
   import dbg_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  dbg_word_t  host_in_data,
   input  logic       host_in_valid,
   output logic       host_in_ready,
   dii_link_if.source flit_out
);

   typedef enum logic {
      S_LEN,
      S_DATA
   } state_e;

   state_e           state;
   logic [LEN_W-1:0] remain;     // flits still to come in this packet
   logic             running;
   logic             out_vld;
   dbg_word_t        out_data;
   logic             out_last;
   logic             take;

   // the host is held off until the first clock edge after reset
   assign host_in_ready = running && (!out_vld || flit_out.ready);
   assign take          = host_in_valid && host_in_ready;

   assign flit_out.valid = out_vld;
   assign flit_out.flit  = out_data;
   assign flit_out.last  = out_last;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= S_LEN;
         remain  <= '0;
         running <= 1'b0;
         out_vld <= 1'b0;
      end else begin
         running <= 1'b1;
         if (flit_out.ready)
            out_vld <= 1'b0;
         if (take) begin
            case (state)
               S_LEN: begin
                  if (host_in_data != '0) begin   // zero length words are skipped
                     remain <= host_in_data[LEN_W-1:0];
                     state  <= S_DATA;
                  end
               end
               S_DATA: begin
                  out_vld <= 1'b1;
                  remain  <= remain - 1'b1;
                  if (remain == LEN_W'(1))
                     state <= S_LEN;
               end
               default: state <= S_LEN;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take && state == S_DATA) begin
         out_data <= host_in_data;
         out_last <= (remain == LEN_W'(1));
      end
   end

   a_len_max : assert property (@(posedge clk) disable iff (!arst_n)
      take && state == S_LEN |-> host_in_data <= MAX_PKT_LEN);

endmodule

//--- rtl/ring_router.sv
module ring_router
   import dbg_pkg::*;
#(
   parameter dbg_word_t STATION_ID = HOST_ID
) (
   input  logic       clk,
   input  logic       arst_n,
   dii_link_if.sink   ring_in,
   dii_link_if.source ring_out,
   dii_link_if.sink   local_in,
   dii_link_if.source local_out
);

   // packets reaching the host station again have passed every other station
   localparam bit CAN_DROP = (STATION_ID == HOST_ID);

   typedef enum logic [1:0] {
      RT_IDLE,
      RT_EJECT,
      RT_FWD,
      RT_DROP
   } route_e;

   route_e    state;
   route_e    cur;
   logic      inj_act;     // a local packet is partly on the ring
   dbg_flit_t ring_q;
   dbg_flit_t eject_q;
   logic      ring_vld;
   logic      eject_vld;
   logic      ring_free;
   logic      eject_free;
   logic      in_take;
   logic      fwd_take;
   logic      ej_take;
   logic      inj_take;

   // between packets the route comes from flit 0
   always_comb begin
      cur = state;
      if (state == RT_IDLE) begin
         if (ring_in.valid) begin
            if (ring_in.flit == STATION_ID)
               cur = RT_EJECT;
            else if (CAN_DROP)
               cur = RT_DROP;
            else
               cur = RT_FWD;
         end
      end
   end

   assign ring_free  = !ring_vld || ring_out.ready;
   assign eject_free = !eject_vld || local_out.ready;

   // the host station never forwards, so no ready path runs all the way round
   assign ring_in.ready = (cur == RT_EJECT && eject_free) || (cur == RT_DROP) ||
                          (!CAN_DROP && cur == RT_FWD && !inj_act && ring_free);
   // a waiting ring packet goes out before a local one while ejection never holds one off
   assign local_in.ready = (inj_act || cur != RT_FWD) && ring_free;

   assign in_take  = ring_in.valid && ring_in.ready;
   assign fwd_take = in_take && cur == RT_FWD;
   assign ej_take  = in_take && cur == RT_EJECT;
   assign inj_take = local_in.valid && local_in.ready;

   assign ring_out.valid  = ring_vld;
   assign ring_out.flit   = ring_q.payload;
   assign ring_out.last   = ring_q.last;
   assign local_out.valid = eject_vld;
   assign local_out.flit  = eject_q.payload;
   assign local_out.last  = eject_q.last;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= RT_IDLE;
         inj_act   <= 1'b0;
         ring_vld  <= 1'b0;
         eject_vld <= 1'b0;
      end else begin
         if (ring_free)
            ring_vld <= fwd_take || inj_take;
         if (eject_free)
            eject_vld <= ej_take;
         if (in_take)
            state <= ring_in.last ? RT_IDLE : cur;   // route held until the last flit
         if (inj_take)
            inj_act <= !local_in.last;
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_take)
         ring_q <= '{payload: ring_in.flit, last: ring_in.last};
      else if (inj_take)
         ring_q <= '{payload: local_in.flit, last: local_in.last};
      if (ej_take)
         eject_q <= '{payload: ring_in.flit, last: ring_in.last};
   end

   a_ring_hold : assert property (@(posedge clk) disable iff (!arst_n)
      ring_out.valid && !ring_out.ready |=>
         ring_out.valid && $stable(ring_out.flit) && $stable(ring_out.last));

endmodule

//--- rtl/ctrl_regs_module.sv
module ctrl_regs_module
   import dbg_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   dii_link_if.sink   req_in,
   dii_link_if.source resp_out,
   output logic       sys_rst,
   output logic       cpu_rst
);

   typedef enum logic {
      S_RX,
      S_TX
   } state_e;

   state_e           state;
   logic [IDX_W-1:0] rx_idx;
   logic [IDX_W-1:0] tx_idx;
   logic [IDX_W-1:0] last_idx;
   dbg_word_t        src_q;
   dbg_type_e        type_q;
   reg_addr_e        addr_q;
   dbg_type_e        resp_type;
   dbg_word_t        rdata;
   logic [1:0]       rst_q;   // bit 0 system reset, bit 1 cpu reset
   logic             req_take;
   logic             resp_take;

   assign req_in.ready = (state == S_RX);
   assign req_take     = req_in.valid && req_in.ready;
   assign resp_take    = resp_out.valid && resp_out.ready;

   assign sys_rst = rst_q[0];
   assign cpu_rst = rst_q[1];

   // decode the captured request into the response type and read data
   always_comb begin
      resp_type = RESP_ERR;
      rdata     = '0;
      if (type_q == REQ_READ) begin
         resp_type = RESP_DATA;
         case (addr_q)
            REG_SYSTEM_ID: rdata = SYSTEM_ID;
            REG_NUM_MOD:   rdata = NUM_MOD;
            REG_RESET:     rdata = dbg_word_t'(rst_q);
            default:       resp_type = RESP_ERR;
         endcase
      end else if (type_q == REQ_WRITE && addr_q == REG_RESET) begin
         resp_type = RESP_ACK;
      end
   end

   // only a data response carries flit 3
   assign last_idx = (resp_type == RESP_DATA) ? IDX_W'(3) : IDX_W'(2);

   always_comb begin
      case (tx_idx)
         'd0:     resp_out.flit = src_q;
         'd1:     resp_out.flit = CTRL_ID;
         'd2:     resp_out.flit = resp_type;
         default: resp_out.flit = rdata;
      endcase
   end

   assign resp_out.valid = (state == S_TX);
   assign resp_out.last  = (tx_idx == last_idx);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= S_RX;
         rx_idx <= '0;
         tx_idx <= '0;
         rst_q  <= 2'b00;
      end else begin
         if (req_take) begin
            rx_idx <= rx_idx + 1'b1;
            if (req_in.last) begin
               rx_idx <= '0;
               state  <= S_TX;
            end
            if (rx_idx == 'd4 && type_q == REQ_WRITE && addr_q == REG_RESET)
               rst_q <= req_in.flit[1:0];
         end
         if (resp_take) begin
            tx_idx <= tx_idx + 1'b1;
            if (resp_out.last) begin
               tx_idx <= '0;
               state  <= S_RX;
            end
         end
      end
   end

   // flit 0 is our own id and is not kept
   always_ff @(posedge clk) begin
      if (req_take) begin
         case (rx_idx)
            'd1:     src_q  <= req_in.flit;
            'd2:     type_q <= dbg_type_e'(req_in.flit);
            'd3:     addr_q <= reg_addr_e'(req_in.flit);
            default: ;
         endcase
      end
   end

   a_req_len : assert property (@(posedge clk) disable iff (!arst_n)
      req_take && rx_idx == ((type_q == REQ_WRITE) ? IDX_W'(4) : IDX_W'(3))
         |-> req_in.last);

endmodule

//--- rtl/host_tx_serializer.sv
module host_tx_serializer
   import dbg_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   dii_link_if.sink  flit_in,
   output dbg_word_t host_out_data,
   output logic      host_out_valid,
   input  logic      host_out_ready
);

   typedef enum logic [1:0] {
      S_FILL,
      S_LEN,
      S_DATA
   } state_e;

   state_e           state;
   dbg_word_t        buffer [MAX_PKT_LEN];
   logic [LEN_W-1:0] count;    // flits stored for the current packet
   logic [IDX_W-1:0] rd_idx;
   logic             in_take;
   logic             out_take;

   assign flit_in.ready = (state == S_FILL);
   assign in_take       = flit_in.valid && flit_in.ready;
   assign out_take      = host_out_valid && host_out_ready;

   assign host_out_valid = (state != S_FILL);
   assign host_out_data  = (state == S_LEN) ? dbg_word_t'(count) : buffer[rd_idx];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= S_FILL;
         count  <= '0;
         rd_idx <= '0;
      end else begin
         case (state)
            S_FILL: begin
               if (in_take) begin
                  count <= count + 1'b1;
                  if (flit_in.last)
                     state <= S_LEN;
               end
            end
            S_LEN: begin
               if (out_take) begin
                  state  <= S_DATA;
                  rd_idx <= '0;
               end
            end
            default: begin
               if (out_take) begin
                  rd_idx <= rd_idx + 1'b1;
                  if (LEN_W'(rd_idx) + 1'b1 == count) begin   // final payload word
                     state <= S_FILL;
                     count <= '0;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (in_take)
         buffer[count[IDX_W-1:0]] <= flit_in.flit;
   end

   a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
      in_take |-> count < MAX_PKT_LEN);

endmodule

//--- rtl/debug_system.sv
module debug_system
   import dbg_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  dbg_word_t host_in_data,
   input  logic      host_in_valid,
   output logic      host_in_ready,
   output dbg_word_t host_out_data,
   output logic      host_out_valid,
   input  logic      host_out_ready,
   output logic      sys_rst,
   output logic      cpu_rst
);

   dii_link_if rx_link ();
   dii_link_if tx_link ();
   dii_link_if ring_0_1 ();
   dii_link_if ring_1_0 ();
   dii_link_if scm_req ();
   dii_link_if scm_resp ();

   host_rx_packetizer u_rx (
      .clk           ( clk           ),
      .arst_n        ( arst_n        ),
      .host_in_data  ( host_in_data  ),
      .host_in_valid ( host_in_valid ),
      .host_in_ready ( host_in_ready ),
      .flit_out      ( rx_link       )
   );

   // station 0 talks to the host, station 1 to the control registers
   ring_router #(.STATION_ID(HOST_ID)) u_station0 (
      .clk       ( clk      ),
      .arst_n    ( arst_n   ),
      .ring_in   ( ring_1_0 ),
      .ring_out  ( ring_0_1 ),
      .local_in  ( rx_link  ),
      .local_out ( tx_link  )
   );

   ring_router #(.STATION_ID(CTRL_ID)) u_station1 (
      .clk       ( clk      ),
      .arst_n    ( arst_n   ),
      .ring_in   ( ring_0_1 ),
      .ring_out  ( ring_1_0 ),
      .local_in  ( scm_resp ),
      .local_out ( scm_req  )
   );

   ctrl_regs_module u_scm (
      .clk      ( clk      ),
      .arst_n   ( arst_n   ),
      .req_in   ( scm_req  ),
      .resp_out ( scm_resp ),
      .sys_rst  ( sys_rst  ),
      .cpu_rst  ( cpu_rst  )
   );

   host_tx_serializer u_tx (
      .clk            ( clk            ),
      .arst_n         ( arst_n         ),
      .flit_in        ( tx_link        ),
      .host_out_data  ( host_out_data  ),
      .host_out_valid ( host_out_valid ),
      .host_out_ready ( host_out_ready )
   );

endmodule

//--- verification/debug_system_tb.sv
module debug_system_tb
   import dbg_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_TRANS = 16;   // requests sent over all tests

   logic        clk;
   logic        arst_n;
   dbg_word_t   host_in_data;
   logic        host_in_valid;
   logic        host_in_ready;
   dbg_word_t   host_out_data;
   logic        host_out_valid;
   logic        host_out_ready;
   logic        sys_rst;
   logic        cpu_rst;

   logic [31:0] rng;
   logic        random_ready;
   logic        held;             // last sampled output word was stalled
   dbg_word_t   held_data;

   debug_system uut (
      .clk            ( clk            ),
      .arst_n         ( arst_n         ),
      .host_in_data   ( host_in_data   ),
      .host_in_valid  ( host_in_valid  ),
      .host_in_ready  ( host_in_ready  ),
      .host_out_data  ( host_out_data  ),
      .host_out_valid ( host_out_valid ),
      .host_out_ready ( host_out_ready ),
      .sys_rst        ( sys_rst        ),
      .cpu_rst        ( cpu_rst        )
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   initial begin
      repeat (NUM_TRANS * 200) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", NUM_TRANS * 200);
      abort_run();
   end

   task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_type(input string name, input dbg_type_e got, input dbg_type_e exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // host_in_ready depends only on registered state, so it is sampled on the falling edge
   task automatic push_word(input dbg_word_t w);
      @(negedge clk);
      host_in_data  = w;
      host_in_valid = 1'b1;
      while (!host_in_ready)
         @(negedge clk);
   endtask

   task automatic send_request(input dbg_word_t dst, input dbg_type_e typ,
                               input dbg_word_t addr, input dbg_word_t wdata);
      push_word((typ == REQ_WRITE) ? 16'd5 : 16'd4);
      push_word(dst);
      push_word(HOST_ID);
      push_word(typ);
      push_word(addr);
      if (typ == REQ_WRITE)
         push_word(wdata);
      @(negedge clk);
      host_in_valid = 1'b0;
   endtask

   task automatic receive_word(output dbg_word_t w);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         if (held) begin   // a stalled word has to stay until the host takes it
            check_bit("host_out_valid", host_out_valid, 1'b1);
            check_word("host_out_data", host_out_data, held_data);
         end
         if (random_ready) begin
            rng            = xorshift(rng);
            host_out_ready = rng[0];
         end else begin
            host_out_ready = 1'b1;
         end
         held      = host_out_valid && !host_out_ready;
         held_data = host_out_data;
         if (host_out_valid && host_out_ready) begin
            w     = host_out_data;
            taken = 1'b1;
         end
      end
   endtask

   task automatic expect_response(input dbg_type_e typ, input dbg_word_t data);
      dbg_word_t w;
      dbg_word_t len;
      len = (typ == RESP_DATA) ? 16'd4 : 16'd3;
      receive_word(w);
      check_word("frame length", w, len);
      receive_word(w);
      check_word("response destination", w, HOST_ID);
      receive_word(w);
      check_word("response source", w, CTRL_ID);
      receive_word(w);
      check_type("response type", dbg_type_e'(w), typ);
      if (typ == RESP_DATA) begin
         receive_word(w);
         check_word("response data", w, data);
      end
      @(negedge clk);
      host_out_ready = 1'b0;   // nothing leaves the DUT unseen between frames
      held           = 1'b0;
   endtask

   task automatic check_resets(input logic sys_exp, input logic cpu_exp);
      check_bit("sys_rst", sys_rst, sys_exp);
      check_bit("cpu_rst", cpu_rst, cpu_exp);
   endtask

   task automatic test_id_read();
      send_request(CTRL_ID, REQ_READ, REG_SYSTEM_ID, '0);
      expect_response(RESP_DATA, SYSTEM_ID);
      send_request(CTRL_ID, REQ_READ, REG_NUM_MOD, '0);
      expect_response(RESP_DATA, NUM_MOD);
   endtask

   task automatic test_reset_write();
      send_request(CTRL_ID, REQ_WRITE, REG_RESET, 16'd3);
      expect_response(RESP_ACK, '0);
      check_resets(1'b1, 1'b1);
      send_request(CTRL_ID, REQ_READ, REG_RESET, '0);
      expect_response(RESP_DATA, 16'd3);
      send_request(CTRL_ID, REQ_WRITE, REG_RESET, 16'd1);
      expect_response(RESP_ACK, '0);
      check_resets(1'b1, 1'b0);
      send_request(CTRL_ID, REQ_WRITE, REG_RESET, 16'd0);
      expect_response(RESP_ACK, '0);
      check_resets(1'b0, 1'b0);
   endtask

   task automatic test_errors();
      send_request(CTRL_ID, REQ_READ, 16'd7, '0);
      expect_response(RESP_ERR, '0);
      send_request(CTRL_ID, REQ_WRITE, REG_SYSTEM_ID, 16'h0003);
      expect_response(RESP_ERR, '0);
      check_resets(1'b0, 1'b0);
      send_request(CTRL_ID, REQ_READ, REG_SYSTEM_ID, '0);
      expect_response(RESP_DATA, SYSTEM_ID);
      send_request(CTRL_ID, REQ_READ, REG_RESET, '0);
      expect_response(RESP_DATA, 16'd0);
   endtask

   task automatic test_unknown_dest();
      send_request(16'd5, REQ_READ, REG_SYSTEM_ID, '0);
      repeat (100) begin
         @(negedge clk);
         if (host_out_valid) begin
            $display("an output word appeared for a request to unknown station 5");
            abort_run();
         end
      end
      send_request(CTRL_ID, REQ_READ, REG_NUM_MOD, '0);
      expect_response(RESP_DATA, NUM_MOD);
   endtask

   task automatic test_backpressure();
      dbg_type_e req_type [4];
      dbg_word_t req_addr [4];
      dbg_word_t req_data [4];
      dbg_type_e rsp_type [4];
      dbg_word_t rsp_data [4];
      req_type = '{REQ_READ, REQ_WRITE, REQ_READ, REQ_READ};
      req_addr = '{REG_SYSTEM_ID, REG_RESET, 16'd7, REG_RESET};
      req_data = '{16'd0, 16'd3, 16'd0, 16'd0};
      rsp_type = '{RESP_DATA, RESP_ACK, RESP_ERR, RESP_DATA};
      rsp_data = '{SYSTEM_ID, 16'd0, 16'd0, 16'd3};
      random_ready = 1'b1;
      fork
         begin
            for (int i = 0; i < 4; i++)
               send_request(CTRL_ID, req_type[i], req_addr[i], req_data[i]);
         end
         begin
            for (int j = 0; j < 4; j++)
               expect_response(rsp_type[j], rsp_data[j]);
         end
      join
      random_ready = 1'b0;
   endtask

   initial begin
      arst_n         = 1'b0;
      host_in_data   = '0;
      host_in_valid  = 1'b0;
      host_out_ready = 1'b0;
      rng            = 32'd1929;
      random_ready   = 1'b0;
      held           = 1'b0;
      held_data      = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      check_bit("host_out_valid", host_out_valid, 1'b0);
      check_resets(1'b0, 1'b0);

      test_id_read();
      test_reset_write();
      test_errors();
      test_unknown_dest();
      test_backpressure();

      $display("TEST OK");
      $finish;
   end

endmodule

//--- list.f
rtl/dbg_pkg.sv
rtl/dii_link_if.sv
rtl/host_rx_packetizer.sv
rtl/ring_router.sv
rtl/ctrl_regs_module.sv
rtl/host_tx_serializer.sv
rtl/debug_system.sv
verification/debug_system_tb.sv

//--- Makefile
TOP = debug_system_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
